//--- discrete_mapper_top.f
+incdir+include
rtl/mapper_pkg.sv
rtl/bank_regs.sv
rtl/prg_map.sv
rtl/ppu_map.sv
rtl/discrete_mapper_top.sv
test/tb_discrete_mapper.sv

//--- include/mapper_macros.svh
// ******************************
// Widths and field positions for the iNES-style flags word
// Only the five kept discrete mappers have numbers here
// ******************************
`ifndef MAPPER_MACROS_SVH
`define MAPPER_MACROS_SVH

// Bus and cartridge address widths
`define MAP_ADDR_W 22
`define CPU_ADDR_W 16
`define PPU_ADDR_W 14

// Mapper numbers from flags[7:0]
`define MAPPER_NROM         8'd0
`define MAPPER_COLOR_DREAMS 8'd11
`define MAPPER_GXROM        8'd66
`define MAPPER_CAMERICA     8'd71
`define MAPPER_HOLY_DIVER   8'd78

// CHR ROM region, bits 21:20 of the cartridge address
`define CHR_ROM_BASE 2'b10

// Bit positions in the 32-bit flags word
`define FLAG_CHR_RAM      15
`define FLAG_VERT_MIRROR  14
`define FLAG_SUBMAPPER_LO 21 // Two bits, 22:21

`endif

//--- rtl/bank_regs.sv
// ******************************
// Bank registers for mappers 11, 66, 71 and 78; NROM has none
// Writes land only when ce is high, on the next clock edge
// ******************************
`timescale 1ns/1ps
`default_nettype none

`include "mapper_macros.svh"

module bank_regs (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     ce,
	input  mapper_pkg::cart_cfg_t    cfg,
	input  mapper_pkg::cpu_bus_t     cpu,
	output mapper_pkg::bank_state_t  banks
);

	logic reg_write;
	logic is_32k_board;

	// Every kept board decodes the whole $8000-$FFFF range
	assign reg_write = ce && cpu.write && cpu.addr[15];

	assign is_32k_board = (cfg.mapper == `MAPPER_COLOR_DREAMS) ||
		(cfg.mapper == `MAPPER_GXROM);

	always_ff @(posedge clk) begin
		if (reset) begin
			banks.prg_bank <= 4'd0;
			banks.chr_bank <= 4'd0;
			// Holy Diver starts from the header mirroring
			banks.mirror <= (cfg.mapper == `MAPPER_HOLY_DIVER) && cfg.vert_mirror;
		end else if (reg_write) begin
			case (cfg.mapper)
				`MAPPER_COLOR_DREAMS: begin
					banks.chr_bank <= cpu.data[7:4];
					banks.prg_bank <= {2'b00, cpu.data[1:0]};
				end
				`MAPPER_GXROM: begin
					banks.prg_bank <= {2'b00, cpu.data[5:4]};
					banks.chr_bank <= {2'b00, cpu.data[1:0]};
				end
				`MAPPER_CAMERICA: begin
					if (cpu.addr[14:13] == 2'b00) begin
						banks.mirror <= cpu.data[4]; // Fire Hawk screen select
					end
					if (cpu.addr[14]) begin
						banks.prg_bank <= cpu.data[3:0]; // $C000-$FFFF bank select
					end
				end
				`MAPPER_HOLY_DIVER: begin
					banks.chr_bank <= cpu.data[7:4];
					banks.mirror   <= cpu.data[3];
					banks.prg_bank <= {1'b0, cpu.data[2:0]};
				end
				default: begin
					banks <= banks; // NROM and unknown numbers ignore writes
				end
			endcase
		end
	end

	// 32 KB boards only have four PRG banks
	a_prg_bank_narrow: assert property (
		@(posedge clk) disable iff (reset)
		(reg_write && is_32k_board) |=> (banks.prg_bank[3:2] == 2'b00)
	) else $error("prg_bank upper bits set after 32 KB board write");

	// No state moves without the enable
	a_hold_without_ce: assert property (
		@(posedge clk) disable iff (reset)
		!ce |=> $stable(banks)
	) else $error("bank state changed while ce was low");

endmodule

`default_nettype wire

//--- rtl/discrete_mapper_top.sv
// ******************************
// Discrete mapper top, mappers 0/11/66/71/78
// Unknown mapper numbers behave as NROM
// ******************************
`timescale 1ns/1ps
`default_nettype none

`include "mapper_macros.svh"

module discrete_mapper_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    ce,
	input  logic [31:0]             flags,
	input  mapper_pkg::cpu_bus_t    cpu,
	input  logic [`PPU_ADDR_W-1:0]  chr_addr,
	output mapper_pkg::prg_out_t    prg,
	output mapper_pkg::ppu_out_t    ppu
);

	mapper_pkg::cart_cfg_t    cfg;
	mapper_pkg::bank_state_t  banks;

	assign cfg.mapper      = flags[7:0];
	assign cfg.chr_ram     = flags[`FLAG_CHR_RAM];
	assign cfg.vert_mirror = flags[`FLAG_VERT_MIRROR];
	assign cfg.submapper   = flags[`FLAG_SUBMAPPER_LO +: 2];

	bank_regs u_bank_regs (
		.clk   (clk),
		.reset (reset),
		.ce    (ce),
		.cfg   (cfg),
		.cpu   (cpu),
		.banks (banks)
	);

	prg_map u_prg_map (
		.cfg   (cfg),
		.cpu   (cpu),
		.banks (banks),
		.prg   (prg)
	);

	ppu_map u_ppu_map (
		.cfg      (cfg),
		.chr_addr (chr_addr),
		.banks    (banks),
		.ppu      (ppu)
	);

endmodule

`default_nettype wire

//--- rtl/mapper_pkg.sv
// ******************************
// Shared bus and state structs for the mapper blocks
// ******************************
`default_nettype none

`include "mapper_macros.svh"

package mapper_pkg;

	// Cartridge configuration, decoded once from flags
	typedef struct packed {
		logic [7:0] mapper;
		logic       chr_ram;     // Pattern tables are RAM
		logic       vert_mirror; // Hardwired vertical mirroring
		logic [1:0] submapper;
	} cart_cfg_t;

	// CPU side of the cartridge edge
	typedef struct packed {
		logic [`CPU_ADDR_W-1:0] addr;
		logic                   write; // One-cycle write strobe
		logic [7:0]             data;
	} cpu_bus_t;

	// Register state written from the CPU bus
	// mirror is the Fire Hawk screen on 71 and the mirroring bit on 78
	typedef struct packed {
		logic [3:0] prg_bank;
		logic [3:0] chr_bank;
		logic       mirror;
	} bank_state_t;

	// Translated PRG access
	typedef struct packed {
		logic [`MAP_ADDR_W-1:0] addr;
		logic                   allow;
	} prg_out_t;

	// Translated PPU access and nametable controls
	typedef struct packed {
		logic [`MAP_ADDR_W-1:0] addr;
		logic                   allow;    // CHR write allowed
		logic                   vram_a10; // Nametable select
		logic                   vram_ce;  // Route to internal 2 KB VRAM
	} ppu_out_t;

endpackage

`default_nettype wire

//--- rtl/ppu_map.sv
// ******************************
// PPU address, CHR allow and nametable mirroring, combinational
// CHR is always 8 KB banks in the ROM region
// ******************************
`timescale 1ns/1ps
`default_nettype none

`include "mapper_macros.svh"

module ppu_map (
	input  mapper_pkg::cart_cfg_t    cfg,
	input  logic [`PPU_ADDR_W-1:0]   chr_addr,
	input  mapper_pkg::bank_state_t  banks,
	output mapper_pkg::ppu_out_t     ppu
);

	logic [3:0] chr_bank;
	logic       fixed_a10;

	// Header mirroring, vertical picks A10
	assign fixed_a10 = cfg.vert_mirror ? chr_addr[10] : chr_addr[11];

	always_comb begin
		case (cfg.mapper)
			`MAPPER_COLOR_DREAMS,
			`MAPPER_GXROM,
			`MAPPER_HOLY_DIVER: begin
				chr_bank = banks.chr_bank;
			end
			default: begin
				chr_bank = 4'd0; // NROM and Camerica have one CHR bank
			end
		endcase
	end

	always_comb begin
		ppu.addr = {`CHR_ROM_BASE, {(`MAP_ADDR_W - 19){1'b0}}, chr_bank, chr_addr[12:0]};
		ppu.allow = cfg.chr_ram;
		ppu.vram_ce = chr_addr[13]; // $2000 and up is nametable space

		case (cfg.mapper)
			`MAPPER_CAMERICA: begin
				// Fire Hawk boards are marked horizontal and use the screen select
				ppu.vram_a10 = cfg.vert_mirror ? chr_addr[10] : banks.mirror;
			end
			`MAPPER_HOLY_DIVER: begin
				if (cfg.submapper == 2'd1) begin
					ppu.vram_a10 = banks.mirror; // JF-16 one-screen
				end else if (banks.mirror) begin
					ppu.vram_a10 = chr_addr[10];
				end else begin
					ppu.vram_a10 = chr_addr[11];
				end
			end
			`MAPPER_NROM,
			`MAPPER_COLOR_DREAMS,
			`MAPPER_GXROM: begin
				ppu.vram_a10 = fixed_a10;
			end
			default: begin
				ppu.vram_a10 = fixed_a10;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/prg_map.sv
// ******************************
// CPU to cartridge address, combinational
// ******************************
`timescale 1ns/1ps
`default_nettype none

`include "mapper_macros.svh"

module prg_map (
	input  mapper_pkg::cart_cfg_t    cfg,
	input  mapper_pkg::cpu_bus_t     cpu,
	input  mapper_pkg::bank_state_t  banks,
	output mapper_pkg::prg_out_t     prg
);

	logic [3:0] bank_16k;

	// Upper half of the window is fixed to the last 16 KB bank
	assign bank_16k = cpu.addr[14] ? 4'hF : banks.prg_bank;

	always_comb begin
		prg.allow = cpu.addr[15] && !cpu.write; // ROM reads only

		case (cfg.mapper)
			`MAPPER_COLOR_DREAMS,
			`MAPPER_GXROM: begin
				prg.addr = {{(`MAP_ADDR_W - 17){1'b0}}, banks.prg_bank[1:0],
					cpu.addr[14:0]}; // 32 KB banks
			end
			`MAPPER_CAMERICA,
			`MAPPER_HOLY_DIVER: begin
				prg.addr = {{(`MAP_ADDR_W - 18){1'b0}}, bank_16k, cpu.addr[13:0]};
			end
			`MAPPER_NROM: begin
				prg.addr = {{(`MAP_ADDR_W - 15){1'b0}}, cpu.addr[14:0]};
			end
			default: begin
				prg.addr = {{(`MAP_ADDR_W - 15){1'b0}}, cpu.addr[14:0]}; // Treat as NROM
			end
		endcase
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the discrete mapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_discrete_mapper \
	-f discrete_mapper_top.f

sim_out=$(./obj_dir/Vtb_discrete_mapper 2>&1 || true)
echo "$sim_out"

# A missing pass line makes grep, and so the script, fail
echo "$sim_out" | grep -q "Simulation passed"

//--- test/tb_discrete_mapper.sv
// ******************************
// Directed tests for mappers 0/11/66/71/78, inputs driven 1 ns after clk rises
// ******************************
`timescale 1ns/1ps
`default_nettype none

`include "mapper_macros.svh"

module tb_discrete_mapper;

	localparam int CYCLE_LIMIT = 400; // Far beyond the length of all tests

	logic                    clk;
	logic                    reset;
	logic                    ce;
	logic [31:0]             flags;
	mapper_pkg::cpu_bus_t    cpu;
	logic [`PPU_ADDR_W-1:0]  chr_addr;
	mapper_pkg::prg_out_t    prg;
	mapper_pkg::ppu_out_t    ppu;
	int                      cycle_count = 0;

	discrete_mapper_top dut0 (
		.clk      (clk),
		.reset    (reset),
		.ce       (ce),
		.flags    (flags),
		.cpu      (cpu),
		.chr_addr (chr_addr),
		.prg      (prg),
		.ppu      (ppu)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: tests still running after %0d cycles", cycle_count);
			$display("Simulation failed");
			$fatal(1, "run did not finish in time");
		end
	end

	function automatic logic [31:0] make_flags(input logic [7:0] mapper, input logic vert,
		input logic chr_ram, input logic [1:0] sub);
		logic [31:0] f;
		f = 32'd0;
		f[7:0] = mapper;
		f[`FLAG_VERT_MIRROR] = vert;
		f[`FLAG_CHR_RAM] = chr_ram;
		f[`FLAG_SUBMAPPER_LO +: 2] = sub;
		return f;
	endfunction

	// Expected cartridge addresses per board type
	function automatic logic [21:0] nrom_prg_addr(input logic [15:0] a);
		return {7'd0, a[14:0]};
	endfunction

	function automatic logic [21:0] prg_32k_addr(input logic [1:0] bank, input logic [15:0] a);
		return {5'd0, bank, a[14:0]};
	endfunction

	function automatic logic [21:0] prg_16k_addr(input logic [3:0] bank, input logic [15:0] a);
		return {4'd0, bank, a[13:0]};
	endfunction

	function automatic logic [21:0] chr_rom_addr(input logic [3:0] bank, input logic [13:0] a);
		return {`CHR_ROM_BASE, 3'd0, bank, a[12:0]};
	endfunction

	function automatic logic mirror_a10(input logic vert, input logic [13:0] a);
		return vert ? a[10] : a[11]; // Vertical uses A10, horizontal A11
	endfunction

	task next_cycle;
		@(posedge clk);
		#1;
	endtask

	task settle;
		@(negedge clk);
	endtask

	task check_addr(input string name, input logic [21:0] expected, input logic [21:0] actual);
		assert (actual == expected) else begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task check_bit(input string name, input logic expected, input logic actual);
		assert (actual == expected) else begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task apply_reset(input logic [31:0] f);
		flags = f;
		reset = 1'b1;
		repeat (2) next_cycle();
		reset = 1'b0;
	endtask

	task write_reg(input logic [15:0] addr, input logic [7:0] data);
		cpu.addr = addr;
		cpu.data = data;
		cpu.write = 1'b1;
		next_cycle(); // Bank state updates on this edge
		cpu.write = 1'b0;
		cpu.data = 8'h00;
	endtask

	task expect_prg(input logic [15:0] addr, input logic [21:0] exp_addr);
		cpu.addr = addr;
		cpu.write = 1'b0;
		settle();
		check_addr("prg.addr", exp_addr, prg.addr);
		check_bit("prg.allow", addr[15], prg.allow);
		next_cycle();
	endtask

	task expect_ppu(input logic [13:0] a, input logic [21:0] exp_addr, input logic exp_a10);
		chr_addr = a;
		settle();
		check_addr("ppu.addr", exp_addr, ppu.addr);
		check_bit("ppu.vram_ce", a[13], ppu.vram_ce);
		check_bit("ppu.vram_a10", exp_a10, ppu.vram_a10);
		next_cycle();
	endtask

	// Write strobe with ce low, so no bank moves
	task check_write_blocked(input logic [15:0] addr);
		cpu.addr = addr;
		cpu.write = 1'b1;
		ce = 1'b0;
		settle();
		check_bit("prg.allow", 1'b0, prg.allow);
		next_cycle();
		cpu.write = 1'b0;
		ce = 1'b1;
	endtask

	task nrom_mapping;
		apply_reset(make_flags(`MAPPER_NROM, 1'b1, 1'b0, 2'd0));
		expect_prg(16'h8123, nrom_prg_addr(16'h8123));
		expect_prg(16'hFFFF, nrom_prg_addr(16'hFFFF));
		expect_prg(16'h4123, nrom_prg_addr(16'h4123)); // Below $8000, no allow
		write_reg(16'hA000, 8'($urandom));
		expect_prg(16'hA5A5, nrom_prg_addr(16'hA5A5));
		check_write_blocked(16'h8000);
		for (int v = 0; v < 2; v++) begin
			flags = make_flags(`MAPPER_NROM, v[0], 1'b0, 2'd0);
			expect_ppu(14'h1ABC, chr_rom_addr(4'h0, 14'h1ABC), mirror_a10(v[0], 14'h1ABC));
			expect_ppu(14'h2400, chr_rom_addr(4'h0, 14'h2400), mirror_a10(v[0], 14'h2400));
			expect_ppu(14'h2800, chr_rom_addr(4'h0, 14'h2800), mirror_a10(v[0], 14'h2800));
		end
	endtask

	task bank_32k_boards(input logic [7:0] mapper);
		logic [7:0] data;
		logic [1:0] prg_bank;
		logic [3:0] chr_bank;
		apply_reset(make_flags(mapper, 1'b1, 1'b0, 2'd0));
		repeat (3) begin
			data = 8'($urandom);
			if (mapper == `MAPPER_GXROM) begin
				prg_bank = data[5:4];
				chr_bank = {2'b00, data[1:0]};
			end else begin
				prg_bank = data[1:0];
				chr_bank = data[7:4];
			end
			write_reg(16'hC000, data);
			expect_prg(16'h9234, prg_32k_addr(prg_bank, 16'h9234));
			expect_prg(16'hF00D, prg_32k_addr(prg_bank, 16'hF00D));
			expect_ppu(14'h0567, chr_rom_addr(chr_bank, 14'h0567), mirror_a10(1'b1, 14'h0567));
		end
	endtask

	task camerica_banks;
		logic [7:0] data;
		apply_reset(make_flags(`MAPPER_CAMERICA, 1'b0, 1'b0, 2'd0));
		repeat (2) begin
			data = 8'($urandom);
			write_reg(16'hC000, data);
			expect_prg(16'h8123, prg_16k_addr(data[3:0], 16'h8123));
			expect_prg(16'hC456, prg_16k_addr(4'hF, 16'hC456)); // Fixed last bank
		end
		write_reg(16'h8000, 8'h10); // Screen select 1
		expect_ppu(14'h2000, chr_rom_addr(4'h0, 14'h2000), 1'b1);
		expect_ppu(14'h2C00, chr_rom_addr(4'h0, 14'h2C00), 1'b1);
		expect_prg(16'h8123, prg_16k_addr(data[3:0], 16'h8123)); // PRG bank untouched
		write_reg(16'h8000, 8'hEF);
		expect_ppu(14'h2C00, chr_rom_addr(4'h0, 14'h2C00), 1'b0);
		flags = make_flags(`MAPPER_CAMERICA, 1'b1, 1'b0, 2'd0);
		expect_ppu(14'h2400, chr_rom_addr(4'h0, 14'h2400), 1'b1);
		expect_ppu(14'h2800, chr_rom_addr(4'h0, 14'h2800), 1'b0);
	endtask

	task holy_diver_banks;
		logic [7:0] data;
		apply_reset(make_flags(`MAPPER_HOLY_DIVER, 1'b0, 1'b0, 2'd0));
		for (int m = 0; m < 2; m++) begin
			data = 8'($urandom);
			data[3] = m[0];
			write_reg(16'h8000, data);
			expect_prg(16'h8123, prg_16k_addr({1'b0, data[2:0]}, 16'h8123));
			expect_prg(16'hC123, prg_16k_addr(4'hF, 16'hC123));
			expect_ppu(14'h0ABC, chr_rom_addr(data[7:4], 14'h0ABC), mirror_a10(m[0], 14'h0ABC));
			expect_ppu(14'h2400, chr_rom_addr(data[7:4], 14'h2400), mirror_a10(m[0], 14'h2400));
			expect_ppu(14'h2800, chr_rom_addr(data[7:4], 14'h2800), mirror_a10(m[0], 14'h2800));
		end
		// JF-16 one-screen, mirror is still 1 from the last write
		flags = make_flags(`MAPPER_HOLY_DIVER, 1'b0, 1'b0, 2'd1);
		expect_ppu(14'h2400, chr_rom_addr(data[7:4], 14'h2400), 1'b1);
		expect_ppu(14'h2800, chr_rom_addr(data[7:4], 14'h2800), 1'b1);
		data = 8'($urandom) & 8'hF7;
		write_reg(16'h8000, data);
		expect_ppu(14'h2400, chr_rom_addr(data[7:4], 14'h2400), 1'b0);
		expect_ppu(14'h2800, chr_rom_addr(data[7:4], 14'h2800), 1'b0);
	endtask

	task enable_reset_allow;
		apply_reset(make_flags(`MAPPER_GXROM, 1'b0, 1'b0, 2'd0));
		write_reg(16'h8000, 8'h31);
		expect_prg(16'h9000, prg_32k_addr(2'd3, 16'h9000));
		expect_ppu(14'h0123, chr_rom_addr(4'h1, 14'h0123), 1'b0);
		ce = 1'b0;
		write_reg(16'h8000, 8'h02);
		write_reg(16'hC000, 8'h10);
		ce = 1'b1;
		expect_prg(16'h9000, prg_32k_addr(2'd3, 16'h9000));
		expect_ppu(14'h0123, chr_rom_addr(4'h1, 14'h0123), 1'b0);
		check_write_blocked(16'hC000);
		apply_reset(make_flags(`MAPPER_GXROM, 1'b0, 1'b0, 2'd0));
		expect_prg(16'h9000, prg_32k_addr(2'd0, 16'h9000));
		expect_ppu(14'h0123, chr_rom_addr(4'h0, 14'h0123), 1'b0);
		flags = make_flags(`MAPPER_GXROM, 1'b0, 1'b1, 2'd0);
		settle();
		check_bit("ppu.allow", 1'b1, ppu.allow);
		next_cycle();
		flags = make_flags(`MAPPER_GXROM, 1'b0, 1'b0, 2'd0);
		settle();
		check_bit("ppu.allow", 1'b0, ppu.allow);
		next_cycle();
		// Holy Diver loads mirror from the header at reset
		apply_reset(make_flags(`MAPPER_HOLY_DIVER, 1'b1, 1'b0, 2'd0));
		expect_ppu(14'h2400, chr_rom_addr(4'h0, 14'h2400), 1'b1);
		expect_ppu(14'h2800, chr_rom_addr(4'h0, 14'h2800), 1'b0);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		ce = 1'b1;
		flags = 32'd0;
		cpu = '0;
		chr_addr = '0;
		void'($urandom(69));
		nrom_mapping();
		bank_32k_boards(`MAPPER_GXROM);
		bank_32k_boards(`MAPPER_COLOR_DREAMS);
		camerica_banks();
		holy_diver_banks();
		enable_reset_allow();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire
